// File: Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_counters.sv
  - csr_trap_regs.sv
  - pmp_lookup.sv
  - csr_read_mux.sv
  - csr_unit.sv
  - target: simulation
    files:
      - csr_checker.sv
      - csr_monitor.sv
      - tb_csr_unit.sv

// File: csr_checker.sv
`default_nettype none

module csr_checker
    import csr_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire csr_rd_req_t rd_req_i,
    input  wire word_t       rd_data_i,
    input  wire word_t       lookup_a_addr_i,
    input  wire logic [2:0]  lookup_a_rwx_i,
    input  wire word_t       lookup_b_addr_i,
    input  wire logic [2:0]  lookup_b_rwx_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    idle_reads_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        !rd_req_i.valid |=> rd_data_i == '0)
        else begin
            failures++;
            $error("Read data is not zero after a cycle without a read strobe");
        end

    reset_clears_read: assert property (@(posedge clk_i) reset_i |=> rd_data_i == '0)
        else begin
            failures++;
            $error("Read data is not zero after reset");
        end

    // Both lookups share one region table
    lookups_agree: assert property (@(posedge clk_i)
        lookup_a_addr_i == lookup_b_addr_i |-> lookup_a_rwx_i == lookup_b_rwx_i)
        else begin
            failures++;
            $error("The two PMP lookups disagree on the same address");
        end

endmodule

bind csr_unit csr_checker u_checker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rd_req_i        (rd_req_i),
    .rd_data_i       (rd_data_o),
    .lookup_a_addr_i (lookup_a_addr_i),
    .lookup_a_rwx_i  (lookup_a_rwx_o),
    .lookup_b_addr_i (lookup_b_addr_i),
    .lookup_b_rwx_i  (lookup_b_rwx_o)
);

`default_nettype wire

// File: csr_counters.sv
`default_nettype none

module csr_counters
    import csr_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire logic        retired_i,
    input  wire csr_wr_req_t wr_req_i,
    output counters_t        counters_o,
    output word_t            inhibit_o
);

    dword_t mcycle_q;
    dword_t mcycle_d;
    dword_t minstret_q;
    dword_t minstret_d;
    word_t  inhibit_q;

    // Advance first, then let a half-word write replace its half
    always_comb begin
        mcycle_d   = inhibit_q[0] ? mcycle_q : mcycle_q + 64'd1;
        minstret_d = minstret_q;
        if (retired_i && !inhibit_q[2]) begin
            minstret_d = minstret_q + 64'd1;
        end

        if (wr_req_i.valid) begin
            case (wr_req_i.addr)
                CSR_MCYCLE,
                CSR_CYCLE:     mcycle_d[31:0]    = wr_req_i.data;
                CSR_MCYCLEH,
                CSR_CYCLEH:    mcycle_d[63:32]   = wr_req_i.data;
                CSR_MINSTRET,
                CSR_INSTRET:   minstret_d[31:0]  = wr_req_i.data;
                CSR_MINSTRETH,
                CSR_INSTRETH:  minstret_d[63:32] = wr_req_i.data;
                default: ;     // Not a counter address
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
            inhibit_q  <= '0;
        end else begin
            mcycle_q   <= mcycle_d;
            minstret_q <= minstret_d;
            if (wr_req_i.valid && wr_req_i.addr == CSR_MCOUNTINHIBIT) begin
                inhibit_q <= wr_req_i.data;
            end
        end
    end

    assign counters_o = '{mcycle: mcycle_q, minstret: minstret_q};
    assign inhibit_o  = inhibit_q;

endmodule

`default_nettype wire

// File: csr_monitor.sv
`default_nettype none

module csr_monitor
    import csr_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       check_en_i,
    input  wire word_t      exp_data_i,
    input  wire word_t      rd_data_i,
    input  wire word_t      addr_a_i,
    input  wire logic [2:0] rwx_a_i,
    input  wire word_t      addr_b_i,
    input  wire logic [2:0] rwx_b_i,
    output int              errors_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic  exp_valid_q = 1'b0;
    word_t exp_data_q  = '0;

    // Memory map: boot ROM, two RAMs, then two peripheral words
    function automatic logic [2:0] expected_rwx(input word_t addr);
        word_t word_base;
        word_base = {addr[31:2], 2'b00};
        if (addr < 32'h0000_1000) begin
            return PERM_R | PERM_X;
        end else if (addr >= 32'h1000_0000 && addr < 32'h1000_1000) begin
            return PERM_R | PERM_W;
        end else if (addr >= 32'h2000_0000 && addr < 32'h2000_1000) begin
            return PERM_R | PERM_W;
        end else if (word_base == 32'hFF00_0004) begin
            return PERM_R | PERM_W;  // Seven-segment display
        end else if (word_base == 32'hFF00_0008) begin
            return PERM_R;           // Switches
        end
        return 3'b000;
    endfunction

    task automatic check_rwx(input string name, input word_t addr, input logic [2:0] got);
        logic [2:0] exp;
        exp = expected_rwx(addr);
        if (got !== exp) begin
            errors_o++;
            $display("Error at %0t: %s for address %h is %b, expected %b",
                     $time, name, addr, got, exp);
        end
    endtask

    initial errors_o = 0;

    // Read data lags its strobe by one edge, permissions do not
    always @(posedge clk_i) begin
        if (exp_valid_q && rd_data_i !== exp_data_q) begin
            errors_o++;
            $display("Error at %0t: rd_data_o is %h, expected %h", $time, rd_data_i, exp_data_q);
        end
        if (check_en_i) begin
            check_rwx("lookup_a_rwx_o", addr_a_i, rwx_a_i);
            check_rwx("lookup_b_rwx_o", addr_b_i, rwx_b_i);
        end
        exp_valid_q <= check_en_i;
        exp_data_q  <= exp_data_i;
    end

endmodule

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // Implemented CSR addresses, anything else reads zero
    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MIP           = 12'h344,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_CYCLE         = 12'hC00,
        CSR_INSTRET       = 12'hC02,
        CSR_CYCLEH        = 12'hC80,
        CSR_INSTRETH      = 12'hC82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        PMP_OFF   = 2'b00, // Null region
        PMP_TOR   = 2'b01, // Top of range
        PMP_NA4   = 2'b10, // Single word
        PMP_NAPOT = 2'b11
    } pmp_mode_e;

    localparam logic [2:0] PERM_R = 3'b001;
    localparam logic [2:0] PERM_W = 3'b010;
    localparam logic [2:0] PERM_X = 3'b100;

    typedef struct packed {
        word_t      addr;      // Byte address >> 2
        logic [2:0] rwx;
        pmp_mode_e  mode;
        logic [1:0] reserved;
        logic       locked;
    } pmp_entry_t;

    localparam int PMP_ENTRIES = 9;

    // Region table in priority order
    localparam pmp_entry_t [0:PMP_ENTRIES-1] PMP_TABLE = '{
        '{addr: 32'h00000000 >> 2, rwx: PERM_R | PERM_X, mode: PMP_NAPOT, reserved: '0, locked: 1'b1},
        '{addr: 32'h00001000 >> 2, rwx: 3'b000,          mode: PMP_OFF,   reserved: '0, locked: 1'b1},
        '{addr: 32'h10000000 >> 2, rwx: PERM_R | PERM_W, mode: PMP_NAPOT, reserved: '0, locked: 1'b1},
        '{addr: 32'h10001000 >> 2, rwx: 3'b000,          mode: PMP_OFF,   reserved: '0, locked: 1'b1},
        '{addr: 32'h20000000 >> 2, rwx: PERM_R | PERM_W, mode: PMP_NAPOT, reserved: '0, locked: 1'b1},
        '{addr: 32'h20001000 >> 2, rwx: 3'b000,          mode: PMP_OFF,   reserved: '0, locked: 1'b1},
        '{addr: 32'hFF000004 >> 2, rwx: PERM_R | PERM_W, mode: PMP_NA4,   reserved: '0, locked: 1'b1},
        '{addr: 32'hFF000008 >> 2, rwx: PERM_R,          mode: PMP_NA4,   reserved: '0, locked: 1'b1},
        '{addr: 32'hFFFFFFFF >> 2, rwx: 3'b000,          mode: PMP_TOR,   reserved: '0, locked: 1'b1}
    };

    // RV32I only: MXL = 1, extension bit I
    localparam word_t MISA_VALUE = 32'h4000_0100;

    typedef struct packed {
        logic        valid;
        logic [11:0] addr;
    } csr_rd_req_t;

    typedef struct packed {
        logic        valid;
        logic [11:0] addr;
        word_t       data;
    } csr_wr_req_t;

    typedef struct packed {
        logic retired;
        logic mtrap;
        logic mret;
    } csr_ctrl_t;

    typedef struct packed {
        logic [23:0] reserved_8;
        logic        mpie;       // Bit 7
        logic [2:0]  reserved_4;
        logic        mie;        // Bit 3
        logic [2:0]  reserved_0;
    } mstatus_t;

    // Shared by mie and mip
    typedef struct packed {
        logic [19:0] reserved_12;
        logic        mei;         // Bit 11
        logic [2:0]  reserved_8;
        logic        mti;         // Bit 7
        logic [2:0]  reserved_4;
        logic        msi;         // Bit 3
        logic [2:0]  reserved_0;
    } mi_t;

    typedef struct packed {
        logic [29:0] base;
        logic [1:0]  mode;
    } mtvec_t;

    typedef struct packed {
        logic        is_interrupt;
        logic [30:0] code;
    } mcause_t;

    typedef struct packed {
        dword_t mcycle;
        dword_t minstret;
    } counters_t;

    typedef struct packed {
        mstatus_t mstatus;
        mi_t      mie;
        mtvec_t   mtvec;
        word_t    mscratch;
        word_t    mepc;
        mcause_t  mcause;
        word_t    mtval;
    } trap_view_t;

endpackage

`default_nettype wire

// File: csr_read_mux.sv
`default_nettype none

module csr_read_mux
    import csr_pkg::*;
#(
    parameter word_t MIMPID_VALUE = 32'd1,
    parameter word_t HART_ID      = 32'd0
) (
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire csr_rd_req_t rd_req_i,
    input  wire counters_t   counters_i,
    input  wire word_t       inhibit_i,
    input  wire trap_view_t  trap_i,
    output word_t            rd_data_o
);

    word_t sel_data;

    always_comb begin
        case (rd_req_i.addr)
            // Identification
            CSR_MISA:          sel_data = MISA_VALUE;
            CSR_MVENDORID:     sel_data = '0;  // Non-commercial
            CSR_MARCHID:       sel_data = '0;
            CSR_MIMPID:        sel_data = MIMPID_VALUE;
            CSR_MHARTID:       sel_data = HART_ID;

            // Trap setup and handling
            CSR_MSTATUS:       sel_data = trap_i.mstatus;
            CSR_MIE:           sel_data = trap_i.mie;
            CSR_MIP:           sel_data = '0;  // Nothing raises interrupts yet
            CSR_MTVEC:         sel_data = trap_i.mtvec;
            CSR_MSCRATCH:      sel_data = trap_i.mscratch;
            CSR_MEPC:          sel_data = trap_i.mepc;
            CSR_MCAUSE:        sel_data = trap_i.mcause;
            CSR_MTVAL:         sel_data = trap_i.mtval;

            // Counters, machine and user aliases
            CSR_MCOUNTINHIBIT: sel_data = inhibit_i;
            CSR_MCYCLE,
            CSR_CYCLE:         sel_data = counters_i.mcycle[31:0];
            CSR_MCYCLEH,
            CSR_CYCLEH:        sel_data = counters_i.mcycle[63:32];
            CSR_MINSTRET,
            CSR_INSTRET:       sel_data = counters_i.minstret[31:0];
            CSR_MINSTRETH,
            CSR_INSTRETH:      sel_data = counters_i.minstret[63:32];

            default:           sel_data = '0;
        endcase
    end

    // One cycle read latency, zero when idle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_data_o <= '0;
        end else if (rd_req_i.valid) begin
            rd_data_o <= sel_data;
        end else begin
            rd_data_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: csr_trap_regs.sv
`default_nettype none

module csr_trap_regs
    import csr_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire logic        mtrap_i,
    input  wire logic        mret_i,
    input  wire csr_wr_req_t wr_req_i,
    output trap_view_t       trap_o
);

    logic     mstatus_mie_q;
    logic     mstatus_mie_d;
    logic     mstatus_mpie_q;
    logic     mstatus_mpie_d;
    logic     meie_q;
    logic     mtie_q;
    logic     msie_q;
    mtvec_t   mtvec_q;
    word_t    mscratch_q;
    word_t    mepc_q;
    mcause_t  mcause_q;
    word_t    mtval_q;

    mstatus_t wr_mstatus;
    mi_t      wr_mi;
    logic     wr_mstatus_hit;

    assign wr_mstatus     = mstatus_t'(wr_req_i.data);
    assign wr_mi          = mi_t'(wr_req_i.data);
    assign wr_mstatus_hit = wr_req_i.valid && (wr_req_i.addr == CSR_MSTATUS);

    // Trap entry and return, an mstatus write in the same cycle wins
    always_comb begin
        mstatus_mie_d  = mstatus_mie_q;
        mstatus_mpie_d = mstatus_mpie_q;
        if (mtrap_i) begin
            mstatus_mie_d  = 1'b0;
            mstatus_mpie_d = mstatus_mie_q;  // Save old enable
        end else if (mret_i) begin
            mstatus_mie_d  = mstatus_mpie_q;
            mstatus_mpie_d = 1'b1;
        end

        if (wr_mstatus_hit) begin
            mstatus_mie_d  = wr_mstatus.mie;
            mstatus_mpie_d = wr_mstatus.mpie;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            meie_q         <= 1'b0;
            mtie_q         <= 1'b0;
            msie_q         <= 1'b0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mtval_q        <= '0;
        end else begin
            mstatus_mie_q  <= mstatus_mie_d;
            mstatus_mpie_q <= mstatus_mpie_d;
            if (wr_req_i.valid) begin
                case (wr_req_i.addr)
                    CSR_MIE: begin  // Machine-level enables only
                        meie_q <= wr_mi.mei;
                        mtie_q <= wr_mi.mti;
                        msie_q <= wr_mi.msi;
                    end
                    CSR_MTVEC:    mtvec_q    <= mtvec_t'(wr_req_i.data);
                    CSR_MSCRATCH: mscratch_q <= wr_req_i.data;
                    CSR_MEPC:     mepc_q     <= wr_req_i.data;
                    CSR_MCAUSE:   mcause_q   <= mcause_t'(wr_req_i.data);
                    CSR_MTVAL:    mtval_q    <= wr_req_i.data;
                    default: ;
                endcase
            end
        end
    end

    assign trap_o.mstatus  = '{mie: mstatus_mie_q, mpie: mstatus_mpie_q, default: '0};
    assign trap_o.mie      = '{mei: meie_q, mti: mtie_q, msi: msie_q, default: '0};
    assign trap_o.mtvec    = mtvec_q;
    assign trap_o.mscratch = mscratch_q;
    assign trap_o.mepc     = mepc_q;
    assign trap_o.mcause   = mcause_q;
    assign trap_o.mtval    = mtval_q;

endmodule

`default_nettype wire

// File: csr_unit.sv
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter word_t MIMPID_VALUE = 32'd1,
    parameter word_t HART_ID      = 32'd0
) (
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire csr_ctrl_t   ctrl_i,
    input  wire csr_rd_req_t rd_req_i,
    input  wire csr_wr_req_t wr_req_i,
    output word_t            rd_data_o,
    input  wire word_t       lookup_a_addr_i,
    output logic [2:0]       lookup_a_rwx_o,
    input  wire word_t       lookup_b_addr_i,
    output logic [2:0]       lookup_b_rwx_o
);

    counters_t  counters;
    word_t      inhibit;
    trap_view_t trap_view;

    // Writes fan out to both banks
    csr_counters u_counters (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .retired_i  (ctrl_i.retired),
        .wr_req_i   (wr_req_i),
        .counters_o (counters),
        .inhibit_o  (inhibit)
    );

    csr_trap_regs u_trap_regs (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .mtrap_i  (ctrl_i.mtrap),
        .mret_i   (ctrl_i.mret),
        .wr_req_i (wr_req_i),
        .trap_o   (trap_view)
    );

    csr_read_mux #(
        .MIMPID_VALUE (MIMPID_VALUE),
        .HART_ID      (HART_ID)
    ) u_read_mux (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rd_req_i   (rd_req_i),
        .counters_i (counters),
        .inhibit_i  (inhibit),
        .trap_i     (trap_view),
        .rd_data_o  (rd_data_o)
    );

    pmp_lookup u_lookup_a (  // Typically instruction fetch
        .addr_i (lookup_a_addr_i),
        .rwx_o  (lookup_a_rwx_o)
    );

    pmp_lookup u_lookup_b (  // Typically data access
        .addr_i (lookup_b_addr_i),
        .rwx_o  (lookup_b_rwx_o)
    );

endmodule

`default_nettype wire

// File: pmp_lookup.sv
`default_nettype none

module pmp_lookup
    import csr_pkg::*;
(
    input  wire word_t  addr_i,  // Byte address
    output logic [2:0]  rwx_o
);

    word_t word_addr;
    logic  found;
    logic  hit;

    // Table holds word addresses
    assign word_addr = {2'b00, addr_i[31:2]};

    // First matching entry wins, the last entry catches the rest
    always_comb begin
        rwx_o = PMP_TABLE[PMP_ENTRIES-1].rwx;
        found = 1'b0;
        hit   = 1'b0;
        for (int i = 0; i < PMP_ENTRIES - 1; i++) begin
            if (PMP_TABLE[i].mode == PMP_NA4) begin
                hit = (word_addr == PMP_TABLE[i].addr);
            end else begin
                hit = (word_addr < PMP_TABLE[i+1].addr);  // Below next boundary
            end
            if (hit && !found) begin
                rwx_o = PMP_TABLE[i].rwx;
                found = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim.f
csr_pkg.sv
csr_counters.sv
csr_trap_regs.sv
pmp_lookup.sv
csr_read_mux.sv
csr_unit.sv
csr_checker.sv
csr_monitor.sv
tb_csr_unit.sv

// File: tb_csr_unit.sv
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD = 40;
    localparam word_t MIMPID     = 32'h0000_0007;
    localparam word_t HART       = 32'h0000_0003;

    localparam csr_ctrl_t NO_CTRL = '{default: 1'b0};
    localparam csr_ctrl_t RETIRE  = '{retired: 1'b1, default: 1'b0};
    localparam csr_ctrl_t TRAP    = '{mtrap: 1'b1, default: 1'b0};
    localparam csr_ctrl_t RET     = '{mret: 1'b1, default: 1'b0};

    // Expected read data belongs to this row's strobe
    typedef struct packed {
        csr_ctrl_t   ctrl;
        csr_rd_req_t rd;
        csr_wr_req_t wr;
        word_t       addr_a;
        word_t       addr_b;
        word_t       exp_data;
    } row_t;

    logic        clk;
    logic        reset;
    csr_ctrl_t   ctrl;
    csr_rd_req_t rd_req;
    csr_wr_req_t wr_req;
    word_t       rd_data;
    word_t       addr_a;
    word_t       addr_b;
    logic [2:0]  rwx_a;
    logic [2:0]  rwx_b;
    word_t       exp_data;
    logic        check_en;
    int          errors;
    int          failures;
    logic        table_ready = 1'b0;

    row_t  rows[$];
    word_t probes[$];

    csr_unit #(
        .MIMPID_VALUE (MIMPID),
        .HART_ID      (HART)
    ) DUT (
        .clk_i           (clk),
        .reset_i         (reset),
        .ctrl_i          (ctrl),
        .rd_req_i        (rd_req),
        .wr_req_i        (wr_req),
        .rd_data_o       (rd_data),
        .lookup_a_addr_i (addr_a),
        .lookup_a_rwx_o  (rwx_a),
        .lookup_b_addr_i (addr_b),
        .lookup_b_rwx_o  (rwx_b)
    );

    csr_monitor u_monitor (
        .clk_i      (clk),
        .check_en_i (check_en),
        .exp_data_i (exp_data),
        .rd_data_i  (rd_data),
        .addr_a_i   (addr_a),
        .rwx_a_i    (rwx_a),
        .addr_b_i   (addr_b),
        .rwx_b_i    (rwx_b),
        .errors_o   (errors)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Mostly near the mapped regions, sometimes anywhere
    function automatic word_t pick_addr();
        word_t base;
        case ($urandom_range(0, 4))
            0: base = 32'h0000_0000;
            1: base = 32'h1000_0000;
            2: base = 32'h2000_0000;
            3: base = 32'hFF00_0000;
            default: return $urandom();
        endcase
        return base + $urandom_range(0, 32'h1FFF);
    endfunction

    task automatic add_row(input csr_ctrl_t c, input csr_rd_req_t rd, input csr_wr_req_t wr,
                           input word_t exp);
        row_t r;
        r.ctrl     = c;
        r.rd       = rd;
        r.wr       = wr;
        r.addr_a   = (probes.size() > 0) ? probes.pop_front() : pick_addr();
        r.addr_b   = (rows.size() % 3 == 0) ? r.addr_a : pick_addr();  // Equal now and then
        r.exp_data = exp;
        rows.push_back(r);
    endtask

    task automatic read_row(input logic [11:0] addr, input word_t exp);
        add_row(NO_CTRL, '{valid: 1'b1, addr: addr}, '0, exp);
    endtask

    task automatic write_row(input logic [11:0] addr, input word_t data,
                             input csr_ctrl_t c = NO_CTRL);
        add_row(c, '0, '{valid: 1'b1, addr: addr, data: data}, '0);
    endtask

    task automatic pulse_row(input csr_ctrl_t c);
        add_row(c, '0, '0, '0);
    endtask

    task automatic build_table();
        csr_addr_e plain_regs[5] = '{CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MTVEC};
        word_t     d;
        word_t     dh;
        int        k;
        probes = '{32'h0000_0000, 32'h0000_0FFC, 32'h0000_1000, 32'h0FFF_FFFF,
                   32'h1000_0000, 32'h1000_0FFC, 32'h1000_1000, 32'h1FFF_FFFC,
                   32'h2000_0000, 32'h2000_0FFF, 32'h2000_1000, 32'hFF00_0000,
                   32'hFF00_0003, 32'hFF00_0004, 32'hFF00_0007, 32'hFF00_0008,
                   32'hFF00_000B, 32'hFF00_000C, 32'hFFFF_FFFF};

        // Identification and unmapped reads
        read_row(CSR_MISA, MISA_VALUE);
        read_row(CSR_MVENDORID, '0);
        read_row(CSR_MARCHID, '0);
        read_row(CSR_MIMPID, MIMPID);
        read_row(CSR_MHARTID, HART);
        read_row(12'h7C0, '0);
        pulse_row(NO_CTRL);
        read_row(CSR_MIP, '0);
        read_row(CSR_MSTATUS, '0);  // Reset value

        foreach (plain_regs[i]) begin
            d = $urandom();
            write_row(plain_regs[i], d);
            read_row(plain_regs[i], d);
        end
        d = $urandom();
        write_row(CSR_MSTATUS, d);
        read_row(CSR_MSTATUS, d & 32'h0000_0088);  // MPIE bit 7, MIE bit 3
        d = $urandom();
        write_row(CSR_MIE, d);
        read_row(CSR_MIE, d & 32'h0000_0888);

        // Trap entry and return
        write_row(CSR_MSTATUS, 32'h0000_0008);
        read_row(CSR_MSTATUS, 32'h0000_0008);
        pulse_row(TRAP);
        read_row(CSR_MSTATUS, 32'h0000_0080);
        pulse_row(RET);
        read_row(CSR_MSTATUS, 32'h0000_0088);
        write_row(CSR_MSTATUS, 32'h0000_0000, TRAP);  // Write beats the trap
        read_row(CSR_MSTATUS, 32'h0000_0000);
        write_row(CSR_MSTATUS, 32'h0000_0008, RET);
        read_row(CSR_MSTATUS, 32'h0000_0008);

        // Frozen cycle counter through both aliases
        write_row(CSR_MCOUNTINHIBIT, 32'h0000_0001);
        read_row(CSR_MCOUNTINHIBIT, 32'h0000_0001);
        d  = $urandom();
        dh = $urandom();
        write_row(CSR_CYCLE, d);
        write_row(CSR_CYCLEH, dh);
        read_row(CSR_MCYCLE, d);
        read_row(CSR_CYCLE, d);
        read_row(CSR_MCYCLEH, dh);
        read_row(CSR_CYCLEH, dh);

        // Start from a nonzero count so both clearing writes matter
        dh = $urandom();
        write_row(CSR_MINSTRETH, dh);
        repeat (2) pulse_row(RETIRE);

        // Retired count, then frozen by bit 2
        write_row(CSR_MINSTRET, '0);
        write_row(CSR_MINSTRETH, '0);
        k = $urandom_range(3, 9);
        repeat (k) pulse_row(RETIRE);
        read_row(CSR_MINSTRET, k);
        read_row(CSR_INSTRET, k);
        read_row(CSR_MINSTRETH, '0);
        write_row(CSR_MCOUNTINHIBIT, 32'h0000_0005);
        repeat (2) pulse_row(RETIRE);
        read_row(CSR_MINSTRET, k);

        // Leftover boundary probes, then random lookups
        while (probes.size() > 0) begin
            pulse_row(NO_CTRL);
        end
        repeat (16) pulse_row(NO_CTRL);
    endtask

    task automatic drive_row(input row_t r);
        ctrl     <= r.ctrl;
        rd_req   <= r.rd;
        wr_req   <= r.wr;
        addr_a   <= r.addr_a;
        addr_b   <= r.addr_b;
        exp_data <= r.exp_data;
        check_en <= 1'b1;
    endtask

    initial begin
        void'($urandom(91));
        reset    = 1'b1;
        ctrl     = '0;
        rd_req   = '{valid: 1'b1, addr: CSR_MISA};  // Reset must override a pending read
        wr_req   = '0;
        addr_a   = '0;
        addr_b   = '0;
        exp_data = '0;
        check_en = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        reset  <= 1'b0;
        rd_req <= '0;
        foreach (rows[i]) begin
            @(posedge clk);
            drive_row(rows[i]);
        end
        @(posedge clk);
        drive_row('0);
        check_en <= 1'b0;
        repeat (2) @(posedge clk);  // Last row's read still in flight
        @(negedge clk);

        failures = DUT.u_checker.failures;
        $display("Done: %0d rows, %0d compare errors, %0d assertion failures",
                 rows.size(), errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Table length plus reset and drain, with margin
    initial begin
        wait (table_ready);
        #((rows.size() + 24) * CLK_PERIOD);
        $display("Watchdog expired at %0t, the stimulus table did not finish", $time);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
